// ==== hdl/proc_timer_cfg.svh ====
`ifndef PROC_TIMER_CFG_SVH
`define PROC_TIMER_CFG_SVH

// ------------------------------------------------------------
// process timer block sizing.
// ------------------------------------------------------------

// number of process timers, 1 to 32, one ready bit each.
`define PT_NUM_TIMERS 16

// eight tickers, fixed by the three-bit ticker number.
`define PT_NUM_TICKERS 8

// field widths of the command word.
`define PT_PERIOD_W 16  // period and data field.
`define PT_SEL_W    5   // unit number field.
`define PT_TICKER_W 3   // ticker number, low bits of unit or data.
`define PT_CTRL_W   7   // control bitmask.

`endif

// ==== hdl/proc_timer_pkg.sv ====
`default_nettype none

`include "proc_timer_cfg.svh"

package proc_timer_pkg;

  // ------------------------------------------------------------
  // command word encodings.
  // ------------------------------------------------------------

  // bit positions in the control field; several may be set at once.
  typedef enum logic [2:0] {
    CB_RESET_TICKERS = 3'd0,  // clear every ticker counter.
    CB_SET_PERIOD    = 3'd1,  // load period of one ticker.
    CB_SET_TICKER    = 3'd2,  // bind timer to a ticker, enables it.
    CB_CLEAR_READY   = 3'd3,  // drop the ready flag.
    CB_ENABLE        = 3'd4,
    CB_DISABLE       = 3'd5,  // wins over enable and bind.
    CB_FORCE_READY   = 3'd6   // set ready if enabled.
  } ctrl_bit_e;

  // register offsets on the APB side.
  typedef enum logic [7:0] {
    REG_CMD   = 8'h00,  // write only.
    REG_READY = 8'h04   // read only.
  } reg_addr_e;

  typedef logic [`PT_CTRL_W-1:0]   ctrl_t;       // indexed by ctrl_bit_e.
  typedef logic [`PT_PERIOD_W-1:0] period_t;
  typedef logic [`PT_TICKER_W-1:0] ticker_sel_t;
  typedef logic [`PT_SEL_W-1:0]    unit_sel_t;

  // layout of a write to REG_CMD, msb first.
  typedef struct packed {
    period_t              data;     // [31:16].
    logic [7-`PT_SEL_W:0] rsvd_hi;  // [15:13], ignored.
    unit_sel_t            unit;     // [12:8] ticker or timer number.
    logic                 rsvd_lo;  // [7], ignored.
    ctrl_t                ctrl;     // [6:0].
  } cmd_word_t;

endpackage

`default_nettype wire

// ==== hdl/timer_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "proc_timer_cfg.svh"

// one decoded command, valid while wr is high.
interface timer_cmd_if;
  import proc_timer_pkg::*;

  logic                      wr;          // single-cycle strobe.
  ctrl_t                     ctrl;
  ticker_sel_t               ticker_sel;  // low bits of unit number.
  logic [`PT_NUM_TIMERS-1:0] timer_hit;   // one-hot unit decode.
  period_t                   data;

  // ------------------------------------------------------------
  // the register block drives, the tickers and timers listen.
  // ------------------------------------------------------------
  modport master (
    output wr, ctrl, ticker_sel, timer_hit, data
  );

  modport ticker (
    input wr, ctrl, ticker_sel, data
  );

  modport timer (
    input wr, ctrl, timer_hit, data
  );

endinterface

`default_nettype wire

// ==== hdl/apb_timer_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "proc_timer_cfg.svh"

module apb_timer_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [7:0]                paddr,
  input  logic [31:0]               pwdata,
  input  logic [`PT_NUM_TIMERS-1:0] rdy_in,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  timer_cmd_if.master               cmd
);
  import proc_timer_pkg::*;

  cmd_word_t word;      // pwdata viewed as a command.
  logic      setup_q;   // previous cycle was a setup phase.
  logic      access;    // qualified access phase.
  logic      is_cmd;
  logic      is_ready;

  // ------------------------------------------------------------
  // APB phase tracking.
  // ------------------------------------------------------------

  // an access phase only counts after a setup phase.
  always_ff @(posedge clk) begin
    if (reset) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel & ~penable;
    end
  end

  assign access = psel & penable & setup_q;
  assign pready = 1'b1;  // zero wait states.

  // address match against the register map.
  always_comb begin
    is_cmd   = 1'b0;
    is_ready = 1'b0;
    case (paddr)
      REG_CMD:   is_cmd   = 1'b1;
      REG_READY: is_ready = 1'b1;
      default:   ;  // unmapped, flagged below.
    endcase
  end

  // error on unmapped offset or on a write to the read-only flags.
  assign pslverr = access & (~(is_cmd | is_ready) | (pwrite & is_ready));

  // ready vector, zero-extended, only during its own read.
  assign prdata = (access && !pwrite && is_ready) ? 32'(rdy_in) : 32'h0;

  // ------------------------------------------------------------
  // command split and unit decode.
  // ------------------------------------------------------------
  assign word           = cmd_word_t'(pwdata);
  assign cmd.wr         = access & pwrite & is_cmd;  // combinational strobe.
  assign cmd.ctrl       = word.ctrl;
  assign cmd.data       = word.data;
  assign cmd.ticker_sel = word.unit[`PT_TICKER_W-1:0];

  // one-hot timer select; numbers beyond the array hit nothing.
  always_comb begin
    cmd.timer_hit = '0;
    for (int i = 0; i < `PT_NUM_TIMERS; i++) begin
      if (int'(word.unit) == i) begin
        cmd.timer_hit[i] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ticker_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "proc_timer_cfg.svh"

module ticker_bank (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       tick,         // external tick pulse.
  timer_cmd_if.ticker                cmd,
  output logic [`PT_NUM_TICKERS-1:0] period_done
);
  import proc_timer_pkg::*;

  logic set_period;     // load one period register.
  logic reset_tickers;  // restart all counters.

  assign set_period    = cmd.wr & cmd.ctrl[CB_SET_PERIOD];
  assign reset_tickers = cmd.wr & cmd.ctrl[CB_RESET_TICKERS];

  // ------------------------------------------------------------
  // one period register and counter per ticker.
  // ------------------------------------------------------------
  for (genvar t = 0; t < `PT_NUM_TICKERS; t++) begin : g_ticker
    period_t period_q;  // programmed divide ratio.
    period_t count_q;   // ticks seen in the current period.
    logic    sel;

    assign sel = (cmd.ticker_sel == ticker_sel_t'(t));

    always_ff @(posedge clk) begin
      if (reset) begin
        period_q <= '0;
        count_q  <= '0;
      end else begin
        if (set_period && sel) begin
          period_q <= cmd.data;
        end
        // wrap one cycle after the match, or on a bank restart.
        if (reset_tickers || period_done[t]) begin
          count_q <= '0;
        end else if (tick) begin
          count_q <= count_q + 1'b1;
        end
      end
    end

    // stays high for a zero period, counter never leaves zero.
    assign period_done[t] = (count_q == period_q);
  end

endmodule

`default_nettype wire

// ==== hdl/process_timer_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "proc_timer_cfg.svh"

module process_timer_array (
  input  logic                       clk,
  input  logic                       reset,
  timer_cmd_if.timer                 cmd,
  input  logic [`PT_NUM_TICKERS-1:0] period_done,
  output logic [`PT_NUM_TIMERS-1:0]  proc_rdy
);
  import proc_timer_pkg::*;

  ticker_sel_t new_ticker;  // binding carried in the data field.

  assign new_ticker = cmd.data[`PT_TICKER_W-1:0];

  // ------------------------------------------------------------
  // per-timer binding, enable and ready flag.
  // ------------------------------------------------------------
  for (genvar p = 0; p < `PT_NUM_TIMERS; p++) begin : g_timer
    ticker_sel_t ticker_q;  // bound ticker.
    logic        en_q;
    logic        rdy_q;
    logic        hit;       // command addresses this timer.
    logic        do_bind;
    logic        do_clear;
    logic        do_enable;
    logic        do_disable;
    logic        do_force;
    logic        drop_rdy;

    assign hit        = cmd.wr & cmd.timer_hit[p];
    assign do_bind    = hit & cmd.ctrl[CB_SET_TICKER];
    assign do_clear   = hit & cmd.ctrl[CB_CLEAR_READY];
    assign do_enable  = hit & cmd.ctrl[CB_ENABLE];
    assign do_disable = hit & cmd.ctrl[CB_DISABLE];
    assign do_force   = hit & cmd.ctrl[CB_FORCE_READY];

    // any control change on the timer restarts its ready flag.
    assign drop_rdy = do_bind | do_enable | do_disable | do_clear;

    always_ff @(posedge clk) begin
      if (reset) begin
        ticker_q <= '0;
        en_q     <= 1'b0;
        rdy_q    <= 1'b0;
      end else begin
        if (do_bind) begin
          ticker_q <= new_ticker;
        end
        en_q  <= ~do_disable & (do_enable | do_bind | en_q);  // disable wins.
        // sticky until cleared, gated by the current enable.
        rdy_q <= ~drop_rdy & en_q & (period_done[ticker_q] | do_force | rdy_q);
      end
    end

    assign proc_rdy[p] = rdy_q;
  end

endmodule

`default_nettype wire

// ==== hdl/proc_timer_block.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "proc_timer_cfg.svh"

module proc_timer_block (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      tick,      // one-cycle tick pulse.
  // APB slave.
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [7:0]                paddr,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  // one ready flag per process timer.
  output logic [`PT_NUM_TIMERS-1:0] proc_rdy
);

  logic [`PT_NUM_TICKERS-1:0] period_done;  // ticker wrap pulses.

  timer_cmd_if cmd_bus ();  // decoded command from the register block.

  // ------------------------------------------------------------
  // register block, tickers and timers.
  // ------------------------------------------------------------
  apb_timer_regs u_regs (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .rdy_in  (proc_rdy),  // ready flags read back.
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cmd     (cmd_bus.master)
  );

  ticker_bank u_tickers (
    .clk         (clk),
    .reset       (reset),
    .tick        (tick),
    .cmd         (cmd_bus.ticker),
    .period_done (period_done)
  );

  process_timer_array u_timers (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd_bus.timer),
    .period_done (period_done),
    .proc_rdy    (proc_rdy)
  );

endmodule

`default_nettype wire

// ==== bench/proc_timer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "proc_timer_cfg.svh"

module proc_timer_tb;
  import proc_timer_pkg::*;

  localparam int NT       = `PT_NUM_TIMERS;
  localparam int NK       = `PT_NUM_TICKERS;
  localparam int MAX_ROWS = 48;
  localparam int RAND_ROWS = 16;

  // control masks built from the bit positions.
  localparam logic [6:0] M_RESET  = 7'b1 << CB_RESET_TICKERS;
  localparam logic [6:0] M_PERIOD = 7'b1 << CB_SET_PERIOD;
  localparam logic [6:0] M_BIND   = 7'b1 << CB_SET_TICKER;
  localparam logic [6:0] M_CLEAR  = 7'b1 << CB_CLEAR_READY;
  localparam logic [6:0] M_ENABLE = 7'b1 << CB_ENABLE;
  localparam logic [6:0] M_DISABL = 7'b1 << CB_DISABLE;
  localparam logic [6:0] M_FORCE  = 7'b1 << CB_FORCE_READY;

  // one stimulus row; rdy and err are only trusted when chk is set.
  typedef struct packed {
    logic        wr;
    logic [7:0]  addr;
    logic [31:0] word;
    logic [7:0]  ticks;
    logic        chk;
    logic [31:0] rdy;
    logic        err;
  } row_t;

  logic           clk;
  logic           reset;
  logic           tick;
  logic           psel;
  logic           penable;
  logic           pwrite;
  logic [7:0]     paddr;
  logic [31:0]    pwdata;
  logic [31:0]    prdata;
  logic           pready;
  logic           pslverr;
  logic [NT-1:0]  proc_rdy;

  row_t           rows [0:MAX_ROWS-1];
  int             n_rows = 0;
  bit             rows_ready = 1'b0;
  integer         seed = 32'h29cc;

  // reference state of the block.
  period_t        m_period [0:NK-1];
  period_t        m_count  [0:NK-1];
  logic [2:0]     m_bind   [0:NT-1];
  logic [NT-1:0]  m_en;
  logic [NT-1:0]  m_rdy;

  proc_timer_block UUT (
    .clk      (clk),
    .reset    (reset),
    .tick     (tick),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .proc_rdy (proc_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  // ------------------------------------------------------------
  // bus and tick drivers enter 1 ns after a rising edge.
  // ------------------------------------------------------------
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    psel    = 1'b1;  // setup phase.
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1 penable = 1'b1;  // access phase.
    #2 err = pslverr;
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #1 penable = 1'b1;
    #2 data = prdata;  // mid access cycle.
    err = pslverr;
    check("pready", pready, 1);
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  // one tick pulse, then one idle cycle.
  task automatic pulse_tick();
    tick = 1'b1;
    @(posedge clk);
    #1 tick = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic check(input string name, input logic [31:0] obs, input logic [31:0] exp);
    if (obs !== exp) begin
      $display("Error at %0t ns: %s observed %h expected %h", $time, name, obs, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------------------
  // reference model.
  // ------------------------------------------------------------
  function automatic logic [31:0] cmd_word(input logic [6:0] c, input int unit, input int data);
    cmd_word = {data[15:0], 3'b000, unit[4:0], 1'b0, c};
  endfunction

  // unmapped offsets and writes to the ready register fail.
  function automatic logic err_for(input logic wr, input logic [7:0] addr);
    logic mapped;
    mapped  = (addr == REG_CMD) || (addr == REG_READY);
    err_for = !mapped || (wr && addr == REG_READY);
  endfunction

  task automatic predict_command(input logic [31:0] word);
    logic [6:0]    c;
    logic [4:0]    u;
    logic [15:0]   d;
    logic [NK-1:0] done_old;
    logic          drop;
    c = word[6:0];
    u = word[12:8];
    d = word[31:16];
    for (int t = 0; t < NK; t++) done_old[t] = (m_period[t] == 0);  // zero period never wraps.
    for (int p = 0; p < NT; p++) begin
      if (int'(u) == p) begin
        drop     = c[CB_SET_TICKER] | c[CB_ENABLE] | c[CB_DISABLE] | c[CB_CLEAR_READY];
        m_rdy[p] = !drop && m_en[p] && (done_old[m_bind[p]] || c[CB_FORCE_READY] || m_rdy[p]);
        if (c[CB_DISABLE]) m_en[p] = 1'b0;  // disable wins.
        else if (c[CB_ENABLE] || c[CB_SET_TICKER]) m_en[p] = 1'b1;
        if (c[CB_SET_TICKER]) m_bind[p] = d[2:0];
      end else begin
        m_rdy[p] = m_en[p] && (done_old[m_bind[p]] || m_rdy[p]);
      end
    end
    if (c[CB_SET_PERIOD]) m_period[u[2:0]] = d;
    if (c[CB_RESET_TICKERS]) begin
      for (int t = 0; t < NK; t++) m_count[t] = '0;
    end
  endtask

  // enabled timers on a zero-period ticker see a completion every cycle.
  task automatic settle_zero_period();
    for (int p = 0; p < NT; p++) begin
      if (m_en[p] && m_period[m_bind[p]] == 0) m_rdy[p] = 1'b1;
    end
  endtask

  task automatic count_tick();
    logic [NK-1:0] fired;
    for (int t = 0; t < NK; t++) begin
      fired[t] = 1'b0;
      if (m_period[t] != 0) begin
        m_count[t] = m_count[t] + 1;
        if (m_count[t] == m_period[t]) begin
          fired[t]   = 1'b1;
          m_count[t] = '0;
        end
      end
    end
    for (int p = 0; p < NT; p++) begin
      if (m_en[p] && fired[m_bind[p]]) m_rdy[p] = 1'b1;
    end
    settle_zero_period();
  endtask

  task automatic add_row(input logic wr, input logic [7:0] addr, input logic [31:0] word,
                         input int ticks, input logic chk, input logic [31:0] rdy,
                         input logic err);
    rows[n_rows] = '{wr, addr, word, ticks[7:0], chk, rdy, err};
    n_rows++;
  endtask

  // ------------------------------------------------------------
  // stimulus table.
  // ------------------------------------------------------------
  task automatic build_table();
    int kind;
    int per;
    int tkr;
    int tmr;
    int nt;
    logic [31:0] w;
    add_row(1, REG_CMD, cmd_word(M_PERIOD, 2, 3), 0, 1, 32'h0000, 0);  // ticker 2 period 3.
    add_row(1, REG_CMD, cmd_word(M_BIND, 5, 2), 2, 1, 32'h0000, 0);    // timer 5 on ticker 2.
    add_row(1, REG_CMD, cmd_word(0, 0, 0), 1, 1, 32'h0020, 0);         // third tick completes.
    add_row(1, REG_CMD, cmd_word(0, 0, 0), 3, 1, 32'h0020, 0);         // stays set.
    add_row(1, REG_CMD, cmd_word(M_CLEAR, 5, 0), 0, 1, 32'h0000, 0);
    add_row(1, REG_CMD, cmd_word(M_FORCE, 5, 0), 0, 1, 32'h0020, 0);
    add_row(1, REG_CMD, cmd_word(M_DISABL, 5, 0), 0, 1, 32'h0000, 0);
    add_row(1, REG_CMD, cmd_word(M_FORCE, 5, 0), 0, 1, 32'h0000, 0);   // ignored while off.
    add_row(1, REG_CMD, cmd_word(0, 0, 0), 3, 1, 32'h0000, 0);         // completion blocked.
    add_row(1, REG_CMD, cmd_word(M_ENABLE, 5, 0), 0, 1, 32'h0000, 0);
    add_row(1, REG_CMD, cmd_word(0, 0, 0), 3, 1, 32'h0020, 0);
    add_row(1, REG_CMD, cmd_word(M_CLEAR, 5, 0), 2, 1, 32'h0000, 0);   // two of three ticks.
    add_row(1, REG_CMD, cmd_word(M_RESET, 0, 0), 2, 1, 32'h0000, 0);   // count restarts.
    add_row(1, REG_CMD, cmd_word(0, 0, 0), 1, 1, 32'h0020, 0);
    add_row(1, REG_CMD, cmd_word(M_PERIOD | M_RESET, 4, 5), 0, 1, 32'h0020, 0);
    add_row(1, REG_CMD, cmd_word(M_CLEAR, 5, 0), 0, 1, 32'h0000, 0);
    add_row(1, REG_CMD, cmd_word(M_BIND, 9, 4), 0, 1, 32'h0000, 0);    // timer 9 on ticker 4.
    add_row(1, REG_CMD, cmd_word(M_BIND, 12, 2), 3, 1, 32'h1020, 0);   // 5 and 12 share ticker 2.
    add_row(1, REG_CMD, cmd_word(M_CLEAR, 5, 0), 2, 1, 32'h1200, 0);
    add_row(1, REG_CMD, cmd_word(M_CLEAR, 12, 0), 1, 1, 32'h1220, 0);
    add_row(0, 8'h10, 32'h0, 0, 1, 32'h1220, 1);                       // unmapped read.
    add_row(1, REG_READY, cmd_word(M_CLEAR, 12, 0), 0, 1, 32'h1220, 1);  // read-only register.
    add_row(1, REG_CMD, cmd_word(M_CLEAR | M_DISABL, 21, 0), 0, 1, 32'h1220, 0);
    add_row(1, 8'h08, cmd_word(M_CLEAR, 5, 0), 0, 1, 32'h1220, 1);
    // random rows are checked against the model only.
    for (int i = 0; i < RAND_ROWS; i++) begin
      kind = $unsigned($random(seed)) % 3;
      per  = 1 + $unsigned($random(seed)) % 6;
      tkr  = $unsigned($random(seed)) % NK;
      tmr  = $unsigned($random(seed)) % NT;
      nt   = $unsigned($random(seed)) % 7;
      case (kind)
        0:       w = cmd_word(M_PERIOD | M_RESET, tkr, per);
        1:       w = cmd_word(M_BIND, tmr, tkr);
        default: w = cmd_word(M_CLEAR, tmr, 0);
      endcase
      add_row(1, REG_CMD, w, nt, 0, 32'h0, 0);
    end
  endtask

  // ------------------------------------------------------------
  // main sequence.
  // ------------------------------------------------------------
  initial begin
    logic        err_obs;
    logic        err_exp;
    logic [31:0] rd;
    row_t        r;
    reset   = 1'b1;
    tick    = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    m_en    = '0;
    m_rdy   = '0;
    for (int t = 0; t < NK; t++) begin
      m_period[t] = '0;
      m_count[t]  = '0;
    end
    for (int p = 0; p < NT; p++) m_bind[p] = '0;
    build_table();
    rows_ready = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    check("proc_rdy", proc_rdy, 0);  // idle after reset.
    check("prdata", prdata, 0);
    check("pslverr", pslverr, 0);
    for (int i = 0; i < n_rows; i++) begin
      r       = rows[i];
      err_exp = err_for(r.wr, r.addr);
      if (r.wr) begin
        apb_write(r.addr, r.word, err_obs);
      end else begin
        apb_read(r.addr, rd, err_obs);
        check("prdata", rd, (r.addr == REG_READY) ? 32'(m_rdy) : 32'h0);
      end
      check("pslverr", err_obs, err_exp);
      if (r.wr && r.addr == REG_CMD) predict_command(r.word);  // failed accesses change nothing.
      settle_zero_period();
      for (int k = 0; k < r.ticks; k++) begin
        pulse_tick();
        count_tick();
      end
      apb_read(REG_READY, rd, err_obs);
      check("prdata", rd, 32'(m_rdy));
      check("pslverr", err_obs, 0);
      check("proc_rdy", proc_rdy, m_rdy);
      if (r.chk) begin
        check("table rdy", r.rdy, 32'(m_rdy));
        check("table err", r.err, err_exp);
      end
    end
    $display("TESTS PASSED");
    $finish;
  end

  // limit scales with the table.
  initial begin
    int max_ticks;
    int limit;
    wait (rows_ready);
    max_ticks = 1;
    for (int i = 0; i < n_rows; i++) begin
      if (rows[i].ticks > max_ticks) max_ticks = rows[i].ticks;
    end
    limit = n_rows * max_ticks * 4 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: the test sequence did not finish within %0d cycles", limit);
    $display("TESTS FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/proc_timer_pkg.sv
hdl/timer_cmd_if.sv
hdl/apb_timer_regs.sv
hdl/ticker_bank.sv
hdl/process_timer_array.sv
hdl/proc_timer_block.sv
bench/proc_timer_tb.sv
